/* design/fpu_cvt.sv */
`timescale 1ns/1ps

module fpu_cvt #(
    parameter int NUM_LANES = 2,
    parameter int TAGW      = 4
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           valid_in,
    output logic                           ready_in,
    input  logic [TAGW-1:0]                tag_in,
    input  logic                           is_itof,
    input  logic                           is_signed,
    input  fpu_pkg::fp32_t [NUM_LANES-1:0] dataa,
    fpu_rsp_if.unit                        rsp
);
    import fpu_pkg::*;

    logic advance;
    logic [NUM_LANES-1:0]       u_sign, u_nan, s1_sign, s1_nan;
    logic [NUM_LANES-1:0][7:0]  u_exp, s1_exp;
    logic [NUM_LANES-1:0][31:0] u_mag, s1_mag;
    logic [NUM_LANES-1:0][4:0]  u_lead, s1_lead;
    logic                       s1_valid, s1_itof, s1_signed;
    logic [TAGW-1:0]            s1_tag, s2_tag;
    fp32_t [NUM_LANES-1:0]      p_result, s2_result;
    fflags_t [NUM_LANES-1:0]    p_flags, s2_flags;
    logic                       s2_valid;

    function automatic logic [4:0] lead_one(logic [31:0] x);
        logic [4:0] pos;
        pos = '0;
        for (int k = 0; k < 32; k++)
            if (x[k])
                pos = k[4:0];
        return pos;
    endfunction

    // Stage 1 unpack
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            u_sign[i] = dataa[i][31];
            u_nan[i]  = 1'b0;
            u_exp[i]  = '0;
            u_lead[i] = '0;
            if (is_itof) begin
                u_sign[i] = is_signed && dataa[i][31];
                u_mag[i]  = u_sign[i] ? -dataa[i] : dataa[i];
                u_lead[i] = lead_one(u_mag[i]);
            end else begin
                u_exp[i] = dataa[i][30:23];
                u_mag[i] = {8'b0, |dataa[i][30:23], dataa[i][22:0]}; // Hidden bit
                u_nan[i] = (&dataa[i][30:23]) && (|dataa[i][22:0]);
            end
        end
    end

    // Stage 2 shift and pack
    always_comb begin
        logic [54:0] shifted;
        logic [31:0] ipart, norm;
        logic [7:0]  sh;
        logic        fbits, big, ovf;
        for (int i = 0; i < NUM_LANES; i++) begin
            p_result[i] = '0;
            p_flags[i]  = '0;
            norm        = s1_mag[i] << (5'd31 - s1_lead[i]);
            sh          = s1_exp[i] - 8'd127;
            shifted     = {23'b0, s1_mag[i]} << sh[4:0];
            big         = s1_exp[i] >= 8'd159; // |x| >= 2^32
            ipart       = (s1_exp[i] >= 8'd127) ? shifted[54:23] : '0;
            fbits       = (s1_exp[i] >= 8'd127) ? |shifted[22:0] : |s1_mag[i];
            ovf         = big || (s1_sign[i] ? ipart > 32'h8000_0000 : ipart > 32'h7FFF_FFFF);
            if (s1_itof) begin
                if (s1_mag[i] != '0) begin
                    p_result[i]            = {s1_sign[i], 8'd127 + {3'b0, s1_lead[i]}, norm[30:8]};
                    p_flags[i][FLAG_NX]    = |norm[7:0];
                end
            end else if (s1_nan[i]) begin
                p_result[i]            = s1_signed ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
                p_flags[i][FLAG_NV]    = 1'b1;
            end else if (s1_signed) begin
                if (ovf) begin
                    p_result[i]         = s1_sign[i] ? 32'h8000_0000 : 32'h7FFF_FFFF;
                    p_flags[i][FLAG_NV] = 1'b1;
                end else begin
                    p_result[i]         = s1_sign[i] ? -ipart : ipart;
                    p_flags[i][FLAG_NX] = fbits;
                end
            end else if (s1_sign[i]) begin
                p_flags[i][FLAG_NV] = big || (ipart != '0); // -1 or below
                p_flags[i][FLAG_NX] = !(big || (ipart != '0)) && fbits;
            end else if (big) begin
                p_result[i]         = 32'hFFFF_FFFF;
                p_flags[i][FLAG_NV] = 1'b1;
            end else begin
                p_result[i]         = ipart;
                p_flags[i][FLAG_NX] = fbits;
            end
        end
    end

    assign advance  = !s2_valid || rsp.ready; // Whole pipe stalls together
    assign ready_in = advance;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= valid_in;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && valid_in) begin
            s1_sign   <= u_sign;
            s1_nan    <= u_nan;
            s1_exp    <= u_exp;
            s1_mag    <= u_mag;
            s1_lead   <= u_lead;
            s1_itof   <= is_itof;
            s1_signed <= is_signed;
            s1_tag    <= tag_in;
        end
        if (advance && s1_valid) begin
            s2_result <= p_result;
            s2_flags  <= p_flags;
            s2_tag    <= s1_tag;
        end
    end

    assign rsp.valid      = s2_valid;
    assign rsp.result     = s2_result;
    assign rsp.fflags     = s2_flags;
    assign rsp.has_fflags = 1'b1;
    assign rsp.tag        = s2_tag;

    a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(rsp.valid)) else $error("cvt response valid is unknown");

endmodule

/* design/fpu_dispatch.sv */
`timescale 1ns/1ps

module fpu_dispatch (
    input  fpu_pkg::fpu_op_e op_type,
    input  logic             valid_in,
    output logic             ready_in,
    output logic             ncp_valid,
    output logic             cvt_valid,
    output logic             is_itof,
    output logic             is_signed,
    input  logic             ncp_ready,
    input  logic             cvt_ready
);
    import fpu_pkg::*;

    unit_sel_e unit_sel;

    always_comb begin
        unit_sel  = UNIT_NCP; // Illegal codes fall through to ncomp
        is_itof   = 1'b0;
        is_signed = 1'b0;
        case (op_type)
            OP_CVT_WS: begin
                unit_sel  = UNIT_CVT;
                is_signed = 1'b1;
            end
            OP_CVT_WUS: begin
                unit_sel = UNIT_CVT;
            end
            OP_CVT_SW: begin
                unit_sel  = UNIT_CVT;
                is_itof   = 1'b1;
                is_signed = 1'b1;
            end
            OP_CVT_SWU: begin
                unit_sel = UNIT_CVT;
                is_itof  = 1'b1;
            end
            default: unit_sel = UNIT_NCP;
        endcase
    end

    assign ncp_valid = valid_in && (unit_sel == UNIT_NCP);
    assign cvt_valid = valid_in && (unit_sel == UNIT_CVT);
    assign ready_in  = (unit_sel == UNIT_CVT) ? cvt_ready : ncp_ready;

    always_comb begin
        assert (!(ncp_valid && cvt_valid)) else $error("dispatch drove both units");
    end

endmodule

/* design/fpu_ncomp.sv */
`timescale 1ns/1ps

module fpu_ncomp #(
    parameter int NUM_LANES = 2,
    parameter int TAGW      = 4
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           valid_in,
    output logic                           ready_in,
    input  logic [TAGW-1:0]                tag_in,
    input  fpu_pkg::fpu_op_e               op_type,
    input  fpu_pkg::fp32_t [NUM_LANES-1:0] dataa,
    input  fpu_pkg::fp32_t [NUM_LANES-1:0] datab,
    fpu_rsp_if.unit                        rsp
);
    import fpu_pkg::*;

    fp32_t [NUM_LANES-1:0]   lane_res, res_q;
    fflags_t [NUM_LANES-1:0] lane_flags, flags_q;
    logic                    has_ff, has_ff_q, valid_q;
    logic [TAGW-1:0]         tag_q;

    function automatic logic is_nan(fp32_t x);
        return (&x[30:23]) && (|x[22:0]);
    endfunction

    function automatic logic is_snan(fp32_t x);
        return is_nan(x) && !x[22];
    endfunction

    // Total order on non-NaN values with -0 below +0
    function automatic logic less_tot(fp32_t a, fp32_t b);
        if (a[31] != b[31])
            return a[31];
        return a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]);
    endfunction

    function automatic logic [9:0] classify(fp32_t x);
        logic [9:0] mask;
        mask = '0;
        if (is_nan(x))
            mask[x[22] ? CLS_QNAN : CLS_SNAN] = 1'b1;
        else if (&x[30:23])
            mask[x[31] ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
        else if (x[30:0] == '0)
            mask[x[31] ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
        else if (x[30:23] == '0)
            mask[x[31] ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
        else
            mask[x[31] ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
        return mask;
    endfunction

    always_comb begin
        fp32_t a, b;
        logic any_nan, any_snan, lt, eq;
        for (int i = 0; i < NUM_LANES; i++) begin
            a        = dataa[i];
            b        = datab[i];
            any_nan  = is_nan(a) || is_nan(b);
            any_snan = is_snan(a) || is_snan(b);
            lt       = less_tot(a, b);
            eq       = (a == b) || ((a[30:0] == '0) && (b[30:0] == '0)); // +0 == -0
            lane_res[i]   = '0;
            lane_flags[i] = '0;
            case (op_type)
                OP_MIN, OP_MAX: begin
                    if (is_nan(a) && is_nan(b))
                        lane_res[i] = CANON_NAN;
                    else if (is_nan(a))
                        lane_res[i] = b;
                    else if (is_nan(b))
                        lane_res[i] = a;
                    else
                        lane_res[i] = (lt ^ (op_type == OP_MAX)) ? a : b;
                    lane_flags[i][FLAG_NV] = any_snan;
                end
                OP_FEQ: begin
                    lane_res[i]            = {31'b0, !any_nan && eq};
                    lane_flags[i][FLAG_NV] = any_snan; // Quiet compare
                end
                OP_FLT: begin
                    lane_res[i]            = {31'b0, !any_nan && !eq && lt};
                    lane_flags[i][FLAG_NV] = any_nan;
                end
                OP_FLE: begin
                    lane_res[i]            = {31'b0, !any_nan && (eq || lt)};
                    lane_flags[i][FLAG_NV] = any_nan;
                end
                OP_SGNJ:  lane_res[i] = {b[31], a[30:0]};
                OP_SGNJN: lane_res[i] = {~b[31], a[30:0]};
                OP_SGNJX: lane_res[i] = {a[31] ^ b[31], a[30:0]};
                OP_CLASS: lane_res[i] = {22'b0, classify(a)};
                default:  lane_flags[i][FLAG_NV] = 1'b1;
            endcase
        end
    end

    assign has_ff   = !(op_type inside {OP_SGNJ, OP_SGNJN, OP_SGNJX, OP_CLASS});
    assign ready_in = !valid_q || rsp.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            valid_q <= 1'b0;
        else if (ready_in)
            valid_q <= valid_in;
    end

    always_ff @(posedge clk) begin
        if (valid_in && ready_in) begin
            res_q    <= lane_res;
            flags_q  <= lane_flags;
            has_ff_q <= has_ff;
            tag_q    <= tag_in;
        end
    end

    assign rsp.valid      = valid_q;
    assign rsp.result     = res_q;
    assign rsp.fflags     = flags_q;
    assign rsp.has_fflags = has_ff_q;
    assign rsp.tag        = tag_q;

    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.valid && !rsp.ready |=> rsp.valid && $stable(rsp.result) && $stable(rsp.tag)
            && $stable(rsp.fflags) && $stable(rsp.has_fflags))
        else $error("ncomp response changed while stalled");

endmodule

/* design/fpu_pkg.sv */
package fpu_pkg;

    typedef logic [31:0] fp32_t;   // One lane operand or result
    typedef logic [4:0]  fflags_t; // {NV, DZ, OF, UF, NX}

    localparam int FLAG_NV = 4;
    localparam int FLAG_NX = 0;

    // Codes 13..15 are illegal
    typedef enum logic [3:0] {
        OP_MIN     = 4'd0,
        OP_MAX     = 4'd1,
        OP_FEQ     = 4'd2,
        OP_FLT     = 4'd3,
        OP_FLE     = 4'd4,
        OP_SGNJ    = 4'd5,
        OP_SGNJN   = 4'd6,
        OP_SGNJX   = 4'd7,
        OP_CLASS   = 4'd8,
        OP_CVT_WS  = 4'd9,
        OP_CVT_WUS = 4'd10,
        OP_CVT_SW  = 4'd11,
        OP_CVT_SWU = 4'd12
    } fpu_op_e;

    typedef enum logic {
        UNIT_NCP = 1'b0,
        UNIT_CVT = 1'b1
    } unit_sel_e;

    localparam fp32_t CANON_NAN = 32'h7FC0_0000;

    // Classify mask bit positions, RISC-V order
    localparam int CLS_NEG_INF  = 0;
    localparam int CLS_NEG_NORM = 1;
    localparam int CLS_NEG_SUB  = 2;
    localparam int CLS_NEG_ZERO = 3;
    localparam int CLS_POS_ZERO = 4;
    localparam int CLS_POS_SUB  = 5;
    localparam int CLS_POS_NORM = 6;
    localparam int CLS_POS_INF  = 7;
    localparam int CLS_SNAN     = 8;
    localparam int CLS_QNAN     = 9;

endpackage

/* design/fpu_rsp_arb.sv */
`timescale 1ns/1ps

module fpu_rsp_arb #(
    parameter int NUM_LANES = 2,
    parameter int TAGW      = 4
) (
    input  logic                            clk,
    input  logic                            arst_n,
    fpu_rsp_if.arb                          ncp,
    fpu_rsp_if.arb                          cvt,
    output logic                            valid_out,
    input  logic                            ready_out,
    output fpu_pkg::fp32_t [NUM_LANES-1:0]  result,
    output fpu_pkg::fflags_t [NUM_LANES-1:0] fflags,
    output logic                            has_fflags,
    output logic [TAGW-1:0]                 tag_out
);
    logic load_en;
    logic both_req;
    logic grant_ncp;
    logic grant_cvt;
    logic rr_ptr; // 0 favors ncomp

    assign load_en  = !valid_out || ready_out; // Output reg empty or draining
    assign both_req = ncp.valid && cvt.valid;

    assign grant_ncp = load_en && ncp.valid && (!cvt.valid || !rr_ptr);
    assign grant_cvt = load_en && cvt.valid && (!ncp.valid || rr_ptr);

    assign ncp.ready = grant_ncp;
    assign cvt.ready = grant_cvt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_out <= 1'b0;
            rr_ptr    <= 1'b0;
        end else begin
            if (load_en)
                valid_out <= grant_ncp || grant_cvt;
            if (load_en && both_req)
                rr_ptr <= ~rr_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_ncp) begin
            result     <= ncp.result;
            fflags     <= ncp.fflags;
            has_fflags <= ncp.has_fflags;
            tag_out    <= ncp.tag;
        end else if (grant_cvt) begin
            result     <= cvt.result;
            fflags     <= cvt.fflags;
            has_fflags <= cvt.has_fflags;
            tag_out    <= cvt.tag;
        end
    end

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && !ready_out |=> valid_out && $stable(result) && $stable(fflags)
            && $stable(has_fflags) && $stable(tag_out))
        else $error("response output changed under back-pressure");

    a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({ncp.ready, cvt.ready})) else $error("more than one unit granted");

endmodule

/* design/fpu_rsp_if.sv */
`timescale 1ns/1ps

interface fpu_rsp_if #(
    parameter int NUM_LANES = 2,
    parameter int TAGW      = 4
);
    import fpu_pkg::*;

    logic                    valid;
    logic                    ready;
    fp32_t [NUM_LANES-1:0]   result;
    fflags_t [NUM_LANES-1:0] fflags;
    logic                    has_fflags;
    logic [TAGW-1:0]         tag;

    modport unit (output valid, result, fflags, has_fflags, tag, input ready);

    // Arbiter side only pushes back
    modport arb (input valid, result, fflags, has_fflags, tag, output ready);

endinterface

/* design/fpu_top.sv */
`timescale 1ns/1ps

module fpu_top #(
    parameter int NUM_LANES = 2,
    parameter int TAGW      = 4
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             valid_in,
    output logic                             ready_in,
    input  logic [TAGW-1:0]                  tag_in,
    input  fpu_pkg::fpu_op_e                 op_type,
    input  fpu_pkg::fp32_t [NUM_LANES-1:0]   dataa,
    input  fpu_pkg::fp32_t [NUM_LANES-1:0]   datab,
    output logic                             valid_out,
    input  logic                             ready_out,
    output fpu_pkg::fp32_t [NUM_LANES-1:0]   result,
    output fpu_pkg::fflags_t [NUM_LANES-1:0] fflags,
    output logic                             has_fflags,
    output logic [TAGW-1:0]                  tag_out
);
    logic ncp_valid, ncp_ready;
    logic cvt_valid, cvt_ready;
    logic is_itof, is_signed;

    fpu_rsp_if #(.NUM_LANES(NUM_LANES), .TAGW(TAGW)) ncp_rsp ();
    fpu_rsp_if #(.NUM_LANES(NUM_LANES), .TAGW(TAGW)) cvt_rsp ();

    fpu_dispatch dispatch (
        .op_type   (op_type),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .ncp_valid (ncp_valid),
        .cvt_valid (cvt_valid),
        .is_itof   (is_itof),
        .is_signed (is_signed),
        .ncp_ready (ncp_ready),
        .cvt_ready (cvt_ready)
    );

    fpu_ncomp #(.NUM_LANES(NUM_LANES), .TAGW(TAGW)) ncomp (
        .clk      (clk),
        .arst_n   (arst_n),
        .valid_in (ncp_valid),
        .ready_in (ncp_ready),
        .tag_in   (tag_in),
        .op_type  (op_type),
        .dataa    (dataa),
        .datab    (datab),
        .rsp      (ncp_rsp.unit)
    );

    fpu_cvt #(.NUM_LANES(NUM_LANES), .TAGW(TAGW)) cvt (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (cvt_valid),
        .ready_in  (cvt_ready),
        .tag_in    (tag_in),
        .is_itof   (is_itof),
        .is_signed (is_signed),
        .dataa     (dataa), // Single operand
        .rsp       (cvt_rsp.unit)
    );

    fpu_rsp_arb #(.NUM_LANES(NUM_LANES), .TAGW(TAGW)) rsp_arb (
        .clk        (clk),
        .arst_n     (arst_n),
        .ncp        (ncp_rsp.arb),
        .cvt        (cvt_rsp.arb),
        .valid_out  (valid_out),
        .ready_out  (ready_out),
        .result     (result),
        .fflags     (fflags),
        .has_fflags (has_fflags),
        .tag_out    (tag_out)
    );

endmodule

/* dv/fpu_tb.sv */
`timescale 1ns/1ps

module fpu_tb;
    import fpu_pkg::*;

    localparam int NL  = 2;
    localparam int TW  = 4;
    localparam int TMO = 1000; // Cycles allowed per wait

    logic             clk = 1'b0;
    logic             arst_n = 1'b0;
    logic             valid_in = 1'b0;
    logic             ready_in;
    logic [TW-1:0]    tag_in = '0;
    fpu_op_e          op_type = OP_MIN;
    fp32_t [NL-1:0]   dataa = '0;
    fp32_t [NL-1:0]   datab = '0;
    logic             valid_out;
    logic             ready_out = 1'b1;
    fp32_t [NL-1:0]   result;
    fflags_t [NL-1:0] fflags;
    logic             has_fflags;
    logic [TW-1:0]    tag_out;

    // Expected responses by tag
    logic [63:0] exp_res [16];
    logic [9:0]  exp_flags [16];
    logic        exp_hff [16];
    logic [15:0] pending = '0;

    integer        seed = 59196;
    int            errors = 0;
    int            err_base = 0;
    int            checks = 0;
    int            tests = 0;
    logic          hung = 1'b0;
    logic          bp_on = 1'b0;
    logic [TW-1:0] next_tag = '0;
    fp32_t         spec [24];

    fpu_top #(.NUM_LANES(NL), .TAGW(TW)) uut (.*);

    always #5 clk = ~clk;

    // Random stalls on the response side
    always @(posedge clk) begin
        #1;
        ready_out = bp_on ? (($random(seed) & 1) != 0) : 1'b1;
    end

    function automatic logic nan_val(fp32_t x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic signed [32:0] order_key(fp32_t x);
        return x[31] ? -$signed({2'b0, x[30:0]}) : $signed({2'b0, x[30:0]});
    endfunction

    function automatic logic [9:0] class_of(fp32_t x);
        int pos;
        if (x[30:23] == 8'hFF && x[22:0] == 23'd0)
            pos = x[31] ? CLS_NEG_INF : CLS_POS_INF;
        else if (x[30:23] == 8'hFF)
            pos = x[22] ? CLS_QNAN : CLS_SNAN;
        else if (x[30:23] != 8'd0)
            pos = x[31] ? CLS_NEG_NORM : CLS_POS_NORM;
        else if (x[22:0] != 23'd0)
            pos = x[31] ? CLS_NEG_SUB : CLS_POS_SUB;
        else
            pos = x[31] ? CLS_NEG_ZERO : CLS_POS_ZERO;
        return 10'd1 << pos;
    endfunction

    // Returns {flags, result} for one lane
    function automatic logic [36:0] ncp_model(fpu_op_e op, fp32_t a, fp32_t b);
        logic               na, nb, sa, sb, a_lo;
        logic signed [32:0] ka, kb;
        fp32_t              r;
        fflags_t            f;
        na   = nan_val(a);
        nb   = nan_val(b);
        sa   = na && !a[22];
        sb   = nb && !b[22];
        ka   = order_key(a);
        kb   = order_key(b);
        a_lo = (ka < kb) || ((ka == kb) && a[31]); // -0 below +0
        r    = '0;
        f    = '0;
        case (op)
            OP_MIN, OP_MAX: begin
                f[FLAG_NV] = sa || sb;
                if (na && nb)
                    r = CANON_NAN;
                else if (na)
                    r = b;
                else if (nb)
                    r = a;
                else
                    r = ((op == OP_MIN) == a_lo) ? a : b;
            end
            OP_FEQ: begin
                r[0]       = !(na || nb) && (ka == kb);
                f[FLAG_NV] = sa || sb;
            end
            OP_FLT: begin
                r[0]       = !(na || nb) && (ka < kb);
                f[FLAG_NV] = na || nb;
            end
            OP_FLE: begin
                r[0]       = !(na || nb) && (ka <= kb);
                f[FLAG_NV] = na || nb;
            end
            OP_SGNJ:  r = {b[31], a[30:0]};
            OP_SGNJN: r = {!b[31], a[30:0]};
            OP_SGNJX: r = {a[31] ^ b[31], a[30:0]};
            OP_CLASS: r = {22'd0, class_of(a)};
            default:  f[FLAG_NV] = 1'b1;
        endcase
        return {f, r};
    endfunction

    function automatic logic [36:0] cvt_model(fpu_op_e op, fp32_t x);
        logic [63:0] ip, m;
        logic        frac, neg, sgn;
        int          e, p;
        fp32_t       r;
        fflags_t     f;
        r   = '0;
        f   = '0;
        sgn = (op == OP_CVT_WS) || (op == OP_CVT_SW);
        if (op == OP_CVT_SW || op == OP_CVT_SWU) begin
            neg = sgn && x[31];
            m   = {32'b0, neg ? (~x + 32'd1) : x};
            p   = -1;
            for (int k = 0; k < 32; k++)
                if (m[k])
                    p = k;
            if (p >= 0) begin
                if (p > 23) begin
                    f[FLAG_NX] = (m & ((64'd1 << (p - 23)) - 64'd1)) != 64'd0;
                    m          = m >> (p - 23);
                end else begin
                    m = m << (23 - p);
                end
                r = {neg, 8'(p + 127), m[22:0]};
            end
            return {f, r};
        end
        if (nan_val(x)) begin
            r          = sgn ? 32'h7FFF_FFFF : 32'hFFFF_FFFF;
            f[FLAG_NV] = 1'b1;
            return {f, r};
        end
        e = int'(x[30:23]) - 127;
        m = {40'b0, x[30:23] != 8'd0, x[22:0]};
        if (e < 0) begin
            ip   = '0;
            frac = m != 64'd0;
        end else if (e >= 32) begin
            ip   = 64'h1_0000_0000; // Too big for any 32-bit result
            frac = 1'b0;
        end else if (e >= 23) begin
            ip   = m << (e - 23);
            frac = 1'b0;
        end else begin
            ip   = m >> (23 - e);
            frac = (m & ((64'd1 << (23 - e)) - 64'd1)) != 64'd0;
        end
        if (sgn && x[31]) begin
            r          = (ip > 64'h8000_0000) ? 32'h8000_0000 : ~ip[31:0] + 32'd1;
            f[FLAG_NV] = ip > 64'h8000_0000;
            f[FLAG_NX] = !f[FLAG_NV] && frac;
        end else if (sgn) begin
            r          = (ip > 64'h7FFF_FFFF) ? 32'h7FFF_FFFF : ip[31:0];
            f[FLAG_NV] = ip > 64'h7FFF_FFFF;
            f[FLAG_NX] = !f[FLAG_NV] && frac;
        end else if (x[31]) begin
            f[FLAG_NV] = ip != 64'd0; // -1 or below
            f[FLAG_NX] = (ip == 64'd0) && frac;
        end else begin
            r          = (ip > 64'hFFFF_FFFF) ? 32'hFFFF_FFFF : ip[31:0];
            f[FLAG_NV] = ip > 64'hFFFF_FFFF;
            f[FLAG_NX] = !f[FLAG_NV] && frac;
        end
        return {f, r};
    endfunction

    always @(posedge clk) begin : scoreboard
        logic [36:0] lr;
        if (arst_n && valid_out && ready_out) begin
            pending[tag_out] <= 1'b0;
            checks           <= checks + 1;
        end
        if (arst_n && valid_in && ready_in) begin
            for (int i = 0; i < NL; i++) begin
                if (op_type inside {OP_CVT_WS, OP_CVT_WUS, OP_CVT_SW, OP_CVT_SWU})
                    lr = cvt_model(op_type, dataa[i]);
                else
                    lr = ncp_model(op_type, dataa[i], datab[i]);
                exp_res[tag_in][32*i +: 32]  <= lr[31:0];
                exp_flags[tag_in][5*i +: 5]  <= lr[36:32];
            end
            exp_hff[tag_in] <= (op_type inside {OP_MIN, OP_MAX, OP_FEQ, OP_FLT, OP_FLE})
                || (op_type >= OP_CVT_WS);
            pending[tag_in] <= 1'b1;
        end
    end

    a_result: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && ready_out |-> result == exp_res[tag_out])
        else flag_error($sformatf("tag %0d result %h, expected %h",
            tag_out, result, exp_res[tag_out]));

    a_flags: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && ready_out |-> fflags == exp_flags[tag_out])
        else flag_error($sformatf("tag %0d fflags %b, expected %b",
            tag_out, fflags, exp_flags[tag_out]));

    a_hff: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && ready_out |-> has_fflags == exp_hff[tag_out])
        else flag_error($sformatf("tag %0d has_fflags %b", tag_out, has_fflags));

    a_tag: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && ready_out |-> pending[tag_out])
        else flag_error($sformatf("response for tag %0d was not outstanding", tag_out));

    a_stall: assert property (@(posedge clk) disable iff (!arst_n)
        valid_out && !ready_out |=> valid_out && $stable(result) && $stable(fflags)
            && $stable(has_fflags) && $stable(tag_out))
        else flag_error("response changed while ready_out was low");

    task automatic flag_error(string msg);
        errors++;
        $display("Error: %0t %s", $time, msg);
    endtask

    task automatic give_up(string what);
        hung     = 1'b1;
        valid_in = 1'b0;
        $display("Timeout after %0d cycles waiting for %s at %0t", TMO, what, $time);
    endtask

    function automatic fp32_t pick();
        int r;
        r = $random(seed);
        return r[0] ? spec[r[12:8] % 24] : fp32_t'($random(seed));
    endfunction

    // Exponents around the 32-bit integer range
    function automatic fp32_t near_int();
        fp32_t r;
        r = $random(seed);
        return {r[31], 8'd110 + {2'b0, r[30:25]}, r[22:0]};
    endfunction

    task automatic send(fpu_op_e op, logic [63:0] a, logic [63:0] b);
        int n;
        n = 0;
        if (hung)
            return;
        if (pending[next_tag])
            valid_in = 1'b0;
        while (pending[next_tag] && n < TMO) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pending[next_tag]) begin
            give_up($sformatf("tag %0d to be free", next_tag));
            return;
        end
        valid_in = 1'b1;
        tag_in   = next_tag;
        op_type  = op;
        dataa    = a;
        datab    = b;
        n        = 0;
        @(negedge clk);
        while (!ready_in && n < TMO) begin
            @(negedge clk);
            n++;
        end
        if (!ready_in) begin
            give_up("ready_in to accept a request");
            return;
        end
        @(posedge clk);
        #1;
        next_tag = next_tag + 1'b1;
    endtask

    task automatic drain(string name);
        int n;
        n        = 0;
        valid_in = 1'b0;
        if (hung)
            return;
        while (pending != '0 && n < TMO) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pending != '0)
            give_up($sformatf("outstanding responses of %s", name));
    endtask

    task automatic check_latency(fpu_op_e op, int want);
        int n;
        n = 0;
        send(op, {pick(), pick()}, {pick(), pick()});
        valid_in = 1'b0;
        while (!valid_out && n <= TMO && !hung) begin
            @(negedge clk);
            n++;
        end
        assert (n == want)
            else flag_error($sformatf("%s gave valid_out after %0d cycles, expected %0d",
                op.name(), n, want));
        drain("latency request");
    endtask

    task automatic end_test(string name);
        tests++;
        $display("Test %0d %s: %s, %0d errors", tests, name,
            (errors == err_base) ? "ok" : "failed", errors - err_base);
        err_base = errors;
    endtask

    initial begin
        spec = '{32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000,
                 32'h7FC0_0000, 32'hFFC0_0001, 32'h7F80_0001, 32'hFFA0_0000,
                 32'h0000_0001, 32'h807F_FFFF, 32'h3F80_0000, 32'hBF80_0000,
                 32'h3FC0_0000, 32'hBF00_0000, 32'h4F00_0000, 32'hCF00_0000,
                 32'h4F80_0000, 32'hCF00_0001, 32'h7FFF_FFFF, 32'h8000_0001,
                 32'h0100_0001, 32'h00FF_FFFF, 32'h7F7F_FFFF, 32'hFFFF_FFFF};
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;
        assert (!valid_out) else flag_error("valid_out high after reset");
        check_latency(OP_FLE, 2);
        check_latency(OP_CVT_SW, 3);
        end_test("reset and idle latency");

        for (int k = 0; k < 9; k++)
            for (int i = 0; i < 24; i++)
                for (int j = 0; j < 24; j++)
                    send(fpu_op_e'(4'(k)), {pick(), spec[i]}, {pick(), spec[j]});
        drain("non-computational ops");
        end_test("non-computational");

        for (int k = 9; k < 13; k++) begin
            for (int i = 0; i < 24; i++)
                send(fpu_op_e'(4'(k)), {near_int(), spec[i]}, {pick(), pick()});
            for (int i = 0; i < 60; i++)
                send(fpu_op_e'(4'(k)), {pick(), near_int()}, {pick(), pick()});
        end
        drain("conversions");
        end_test("conversions");

        for (int k = 13; k < 16; k++)
            for (int i = 0; i < 8; i++)
                send(fpu_op_e'(4'(k)), {pick(), pick()}, {pick(), pick()});
        drain("illegal ops");
        end_test("illegal op codes");

        for (int k = 0; k < 200; k++)
            send(k[0] ? fpu_op_e'(4'(9 + (k / 2) % 4)) : fpu_op_e'(4'(k % 9)),
                {pick(), near_int()}, {pick(), pick()});
        drain("mixed traffic");
        end_test("mixed round-robin");

        bp_on = 1'b1;
        for (int k = 0; k < 300; k++)
            send(fpu_op_e'(4'($random(seed))), {near_int(), pick()}, {pick(), pick()});
        drain("back-pressure traffic");
        bp_on = 1'b0;
        end_test("back-pressure");

        $display("Summary: %0d tests, %0d responses checked, %0d errors%s",
            tests, checks, errors, hung ? ", run stopped by a timeout" : "");
        if (errors == 0 && !hung)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fpu_tb \
    -f vlog.f --Mdir obj_dir -o fpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* vlog.f */
design/fpu_pkg.sv
design/fpu_rsp_if.sv
design/fpu_dispatch.sv
design/fpu_ncomp.sv
design/fpu_cvt.sv
design/fpu_rsp_arb.sv
design/fpu_top.sv
dv/fpu_tb.sv
